/* hdl/intt_mask_pkg.sv */
/*
 * Masked INTT stage 1 shared definitions
 * Modulus, widths, pipeline latencies and the random-word layout,
 * plus the small modulo-q helpers used by every arithmetic stage
 */
package intt_mask_pkg;

    localparam int MLKEM_Q       = 3329;
    localparam int Q_WIDTH       = 12;
    localparam int SHARES        = 2;
    localparam int COEFS         = 4;

    // Words 0..3 mask the coefficients, words 4..7 refresh the butterflies
    localparam int RND_WORDS     = 8;
    localparam int RND_WIDTH     = RND_WORDS * Q_WIDTH;
    localparam int REFRESH_WIDTH = (RND_WORDS - COEFS) * Q_WIDTH;

    localparam int SPLIT_LAT     = 1;
    localparam int MUL_LAT       = 2;
    localparam int BF_LAT        = 4;
    localparam int OUT_LAT       = 1;
    localparam int STAGE_LAT     = SPLIT_LAT + BF_LAT + OUT_LAT;

    // Product is below q*q, so the quotient estimate is at most one short
    localparam int BARRETT_K     = 26;
    localparam int BARRETT_M     = (1 << BARRETT_K) / MLKEM_Q;

    // One conditional subtraction, valid for any 12-bit input
    function automatic logic [Q_WIDTH-1:0] reduce_q(input logic [Q_WIDTH-1:0] x);
        logic [Q_WIDTH-1:0] r;
        r = x;
        if (x >= Q_WIDTH'(MLKEM_Q)) begin
            r = x - Q_WIDTH'(MLKEM_Q);
        end
        return r;
    endfunction

    // Operands below q
    function automatic logic [Q_WIDTH-1:0] add_mod_q(input logic [Q_WIDTH-1:0] a,
                                                     input logic [Q_WIDTH-1:0] b);
        logic [Q_WIDTH:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= (Q_WIDTH+1)'(MLKEM_Q)) begin
            s = s - (Q_WIDTH+1)'(MLKEM_Q);
        end
        return s[Q_WIDTH-1:0];
    endfunction

    function automatic logic [Q_WIDTH-1:0] sub_mod_q(input logic [Q_WIDTH-1:0] a,
                                                     input logic [Q_WIDTH-1:0] b);
        logic [Q_WIDTH:0] d;
        d = {1'b0, a} + (Q_WIDTH+1)'(MLKEM_Q) - {1'b0, b};
        if (d >= (Q_WIDTH+1)'(MLKEM_Q)) begin
            d = d - (Q_WIDTH+1)'(MLKEM_Q);
        end
        return d[Q_WIDTH-1:0];
    endfunction

endpackage

/* hdl/pipe_delay.sv */
/*
 * Generic delay line
 * DEPTH registers of payload type T, cleared by reset or zeroize
 */
`timescale 1ns/1ps

module pipe_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize_i,
    input  T     d_i,
    output T     q_o
);

    T stage_q [DEPTH];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else if (zeroize_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q_o = stage_q[DEPTH-1];

endmodule

/* hdl/mod_mul_q.sv */
/*
 * Modular multiplier, two pipeline stages
 * Stage 1 registers the full product, stage 2 applies Barrett
 * reduction with a single correction step
 */
`timescale 1ns/1ps

module mod_mul_q
    import intt_mask_pkg::*;
(
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  logic [Q_WIDTH-1:0] a_i,
    input  logic [Q_WIDTH-1:0] b_i,
    output logic [Q_WIDTH-1:0] p_o
);

    logic [2*Q_WIDTH-1:0] prod_q;
    logic [4*Q_WIDTH-1:0] barrett_t;
    logic [2*Q_WIDTH-1:0] quot;
    logic [2*Q_WIDTH-1:0] rem;
    logic [Q_WIDTH-1:0]   red;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
        end else begin
            prod_q <= (2*Q_WIDTH)'(a_i) * (2*Q_WIDTH)'(b_i);
        end
    end

    always_comb begin
        barrett_t = (4*Q_WIDTH)'(prod_q) * (4*Q_WIDTH)'(BARRETT_M);
        quot      = (2*Q_WIDTH)'(barrett_t >> BARRETT_K);
        rem       = prod_q - quot * (2*Q_WIDTH)'(MLKEM_Q);
        // Remainder lies in [0, 2q)
        if (rem >= (2*Q_WIDTH)'(MLKEM_Q)) begin
            red = Q_WIDTH'(rem - (2*Q_WIDTH)'(MLKEM_Q));
        end else begin
            red = Q_WIDTH'(rem);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p_o <= '0;
        end else if (zeroize_i) begin
            p_o <= '0;
        end else begin
            p_o <= red;
        end
    end

    p_below_q: assert property (@(posedge clk) disable iff (!reset_n) p_o < MLKEM_Q);

endmodule

/* hdl/mask_share_split.sv */
/*
 * Input masking
 * Splits each of the four coefficients into two arithmetic shares
 * modulo q and registers them together with the refresh randomness
 */
`timescale 1ns/1ps

module mask_share_split
    import intt_mask_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize_i,
    input  logic                           valid_i,
    input  logic [Q_WIDTH-1:0]             u00_i,
    input  logic [Q_WIDTH-1:0]             v00_i,
    input  logic [Q_WIDTH-1:0]             u01_i,
    input  logic [Q_WIDTH-1:0]             v01_i,
    input  logic [RND_WIDTH-1:0]           rnd_i,
    output logic [SHARES-1:0][Q_WIDTH-1:0] u00_sh_o,
    output logic [SHARES-1:0][Q_WIDTH-1:0] v00_sh_o,
    output logic [SHARES-1:0][Q_WIDTH-1:0] u01_sh_o,
    output logic [SHARES-1:0][Q_WIDTH-1:0] v01_sh_o,
    output logic [REFRESH_WIDTH-1:0]       refresh_rnd_o
);

    logic [Q_WIDTH-1:0]             coef [COEFS];
    logic [Q_WIDTH-1:0]             mask [COEFS];
    logic [SHARES-1:0][Q_WIDTH-1:0] sh_d [COEFS];
    logic [SHARES-1:0][Q_WIDTH-1:0] sh_q [COEFS];

    always_comb begin
        coef[0] = u00_i;
        coef[1] = v00_i;
        coef[2] = u01_i;
        coef[3] = v01_i;
        for (int i = 0; i < COEFS; i++) begin
            // Raw 12-bit words can exceed q
            mask[i]    = reduce_q(rnd_i[i*Q_WIDTH +: Q_WIDTH]);
            sh_d[i][0] = mask[i];
            sh_d[i][1] = sub_mod_q(coef[i], mask[i]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < COEFS; i++) begin
                sh_q[i] <= '0;
            end
            refresh_rnd_o <= '0;
        end else if (zeroize_i) begin
            for (int i = 0; i < COEFS; i++) begin
                sh_q[i] <= '0;
            end
            refresh_rnd_o <= '0;
        end else begin
            for (int i = 0; i < COEFS; i++) begin
                sh_q[i] <= sh_d[i];
            end
            refresh_rnd_o <= rnd_i[COEFS*Q_WIDTH +: REFRESH_WIDTH];
        end
    end

    assign u00_sh_o = sh_q[0];
    assign v00_sh_o = sh_q[1];
    assign u01_sh_o = sh_q[2];
    assign v01_sh_o = sh_q[3];

    // Share arithmetic assumes canonical coefficients from the caller
    coef_below_q: assert property (@(posedge clk) disable iff (!reset_n)
        valid_i |-> (u00_i < MLKEM_Q) && (v00_i < MLKEM_Q) &&
                    (u01_i < MLKEM_Q) && (v01_i < MLKEM_Q));

endmodule

/* hdl/masked_gs_butterfly.sv */
/*
 * Masked Gentleman-Sande butterfly
 * Works share by share: u' = u + v, v' = (u - v) * w modulo q,
 * with the public twiddle applied to each share. The result shares
 * are refreshed with new randomness. Latency is four cycles
 */
`timescale 1ns/1ps

module masked_gs_butterfly
    import intt_mask_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize_i,
    input  logic [SHARES-1:0][Q_WIDTH-1:0] u_sh_i,
    input  logic [SHARES-1:0][Q_WIDTH-1:0] v_sh_i,
    input  logic [Q_WIDTH-1:0]             w_i,
    input  logic [1:0][Q_WIDTH-1:0]        rnd_i,
    output logic [SHARES-1:0][Q_WIDTH-1:0] u_sh_o,
    output logic [SHARES-1:0][Q_WIDTH-1:0] v_sh_o
);

    logic [SHARES-1:0][Q_WIDTH-1:0] sum_q;
    logic [SHARES-1:0][Q_WIDTH-1:0] diff_q;
    logic [Q_WIDTH-1:0]             w_q;
    logic [SHARES-1:0][Q_WIDTH-1:0] sum_dly;
    logic [SHARES-1:0][Q_WIDTH-1:0] prod_sh;
    logic [1:0][Q_WIDTH-1:0]        rnd_dly;
    logic [Q_WIDTH-1:0]             r_u;
    logic [Q_WIDTH-1:0]             r_v;

    // Add/sub stage, twiddle aligned with the difference
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_q  <= '0;
            diff_q <= '0;
            w_q    <= '0;
        end else if (zeroize_i) begin
            sum_q  <= '0;
            diff_q <= '0;
            w_q    <= '0;
        end else begin
            for (int s = 0; s < SHARES; s++) begin
                sum_q[s]  <= add_mod_q(u_sh_i[s], v_sh_i[s]);
                diff_q[s] <= sub_mod_q(u_sh_i[s], v_sh_i[s]);
            end
            w_q <= w_i;
        end
    end

    for (genvar s = 0; s < SHARES; s++) begin : g_mul
        mod_mul_q i_mul (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .a_i       (diff_q[s]),
            .b_i       (w_q),
            .p_o       (prod_sh[s])
        );
    end

    // Sum shares wait out the multiplier
    pipe_delay #(
        .T     (logic [SHARES-1:0][Q_WIDTH-1:0]),
        .DEPTH (MUL_LAT)
    ) i_sum_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .d_i       (sum_q),
        .q_o       (sum_dly)
    );

    pipe_delay #(
        .T     (logic [1:0][Q_WIDTH-1:0]),
        .DEPTH (BF_LAT - 1)
    ) i_rnd_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .d_i       (rnd_i),
        .q_o       (rnd_dly)
    );

    assign r_u = reduce_q(rnd_dly[0]);
    assign r_v = reduce_q(rnd_dly[1]);

    // Refresh: +r on share 0, -r on share 1, so the sum is unchanged
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            u_sh_o <= '0;
            v_sh_o <= '0;
        end else if (zeroize_i) begin
            u_sh_o <= '0;
            v_sh_o <= '0;
        end else begin
            u_sh_o[0] <= add_mod_q(sum_dly[0], r_u);
            u_sh_o[1] <= sub_mod_q(sum_dly[1], r_u);
            v_sh_o[0] <= add_mod_q(prod_sh[0], r_v);
            v_sh_o[1] <= sub_mod_q(prod_sh[1], r_v);
        end
    end

    shares_below_q: assert property (@(posedge clk) disable iff (!reset_n)
        (u_sh_o[0] < MLKEM_Q) && (u_sh_o[1] < MLKEM_Q) &&
        (v_sh_o[0] < MLKEM_Q) && (v_sh_o[1] < MLKEM_Q));

endmodule

/* hdl/masked_butterfly1x2.sv */
/*
 * First INTT stage on masked operands
 * Two masked butterflies, share combining, halving modulo q
 * and the output register. Latency is BF_LAT + 1 cycles
 */
`timescale 1ns/1ps

module masked_butterfly1x2
    import intt_mask_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize_i,
    input  logic [SHARES-1:0][Q_WIDTH-1:0] u00_sh_i,
    input  logic [SHARES-1:0][Q_WIDTH-1:0] v00_sh_i,
    input  logic [SHARES-1:0][Q_WIDTH-1:0] u01_sh_i,
    input  logic [SHARES-1:0][Q_WIDTH-1:0] v01_sh_i,
    input  logic [Q_WIDTH-1:0]             w0_i,
    input  logic [Q_WIDTH-1:0]             w1_i,
    input  logic [REFRESH_WIDTH-1:0]       refresh_rnd_i,
    output logic [Q_WIDTH-1:0]             u20_o,
    output logic [Q_WIDTH-1:0]             u21_o,
    output logic [Q_WIDTH-1:0]             v20_o,
    output logic [Q_WIDTH-1:0]             v21_o
);

    logic [SHARES-1:0][Q_WIDTH-1:0] bf_u_sh [2];
    logic [SHARES-1:0][Q_WIDTH-1:0] bf_v_sh [2];
    logic [Q_WIDTH-1:0]             comb_res [COEFS];
    logic [Q_WIDTH-1:0]             half_res [COEFS];
    logic [Q_WIDTH-1:0]             res_q [COEFS];

    // x/2 mod q, odd values are lifted by q first
    function automatic logic [Q_WIDTH-1:0] half_mod_q(input logic [Q_WIDTH-1:0] x);
        logic [Q_WIDTH:0] t;
        t = {1'b0, x};
        if (x[0]) begin
            t = t + (Q_WIDTH+1)'(MLKEM_Q);
        end
        return t[Q_WIDTH:1];
    endfunction

    masked_gs_butterfly i_bf0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .u_sh_i    (u00_sh_i),
        .v_sh_i    (v00_sh_i),
        .w_i       (w0_i),
        .rnd_i     (refresh_rnd_i[0 +: 2*Q_WIDTH]),
        .u_sh_o    (bf_u_sh[0]),
        .v_sh_o    (bf_v_sh[0])
    );

    masked_gs_butterfly i_bf1 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .u_sh_i    (u01_sh_i),
        .v_sh_i    (v01_sh_i),
        .w_i       (w1_i),
        .rnd_i     (refresh_rnd_i[2*Q_WIDTH +: 2*Q_WIDTH]),
        .u_sh_o    (bf_u_sh[1]),
        .v_sh_o    (bf_v_sh[1])
    );

    // Unmask and halve, order matches u20, u21, v20, v21
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            comb_res[2*b]   = add_mod_q(bf_u_sh[b][0], bf_u_sh[b][1]);
            comb_res[2*b+1] = add_mod_q(bf_v_sh[b][0], bf_v_sh[b][1]);
        end
        for (int i = 0; i < COEFS; i++) begin
            half_res[i] = half_mod_q(comb_res[i]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < COEFS; i++) begin
                res_q[i] <= '0;
            end
        end else if (zeroize_i) begin
            for (int i = 0; i < COEFS; i++) begin
                res_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < COEFS; i++) begin
                res_q[i] <= half_res[i];
            end
        end
    end

    assign u20_o = res_q[0];
    assign u21_o = res_q[1];
    assign v20_o = res_q[2];
    assign v21_o = res_q[3];

endmodule

/* hdl/intt_stage1_top.sv */
/*
 * Masked ML-KEM INTT stage 1, top level
 * Input masking, two masked butterflies and unmasked halving,
 * with the valid strobe carried alongside. Latency STAGE_LAT cycles
 */
`timescale 1ns/1ps

module intt_stage1_top
    import intt_mask_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize_i,
    input  logic                 valid_i,
    input  logic [Q_WIDTH-1:0]   u00_i,
    input  logic [Q_WIDTH-1:0]   v00_i,
    input  logic [Q_WIDTH-1:0]   u01_i,
    input  logic [Q_WIDTH-1:0]   v01_i,
    input  logic [Q_WIDTH-1:0]   w0_i,
    input  logic [Q_WIDTH-1:0]   w1_i,
    input  logic [RND_WIDTH-1:0] rnd_i,
    output logic                 valid_o,
    output logic [Q_WIDTH-1:0]   u20_o,
    output logic [Q_WIDTH-1:0]   u21_o,
    output logic [Q_WIDTH-1:0]   v20_o,
    output logic [Q_WIDTH-1:0]   v21_o
);

    logic [SHARES-1:0][Q_WIDTH-1:0] u00_sh;
    logic [SHARES-1:0][Q_WIDTH-1:0] v00_sh;
    logic [SHARES-1:0][Q_WIDTH-1:0] u01_sh;
    logic [SHARES-1:0][Q_WIDTH-1:0] v01_sh;
    logic [REFRESH_WIDTH-1:0]       refresh_rnd;
    logic [1:0][Q_WIDTH-1:0]        w_dly;

    mask_share_split i_split (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .valid_i       (valid_i),
        .u00_i         (u00_i),
        .v00_i         (v00_i),
        .u01_i         (u01_i),
        .v01_i         (v01_i),
        .rnd_i         (rnd_i),
        .u00_sh_o      (u00_sh),
        .v00_sh_o      (v00_sh),
        .u01_sh_o      (u01_sh),
        .v01_sh_o      (v01_sh),
        .refresh_rnd_o (refresh_rnd)
    );

    // Twiddles travel with the shares out of the split stage
    pipe_delay #(
        .T     (logic [1:0][Q_WIDTH-1:0]),
        .DEPTH (SPLIT_LAT)
    ) i_w_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .d_i       ({w1_i, w0_i}),
        .q_o       (w_dly)
    );

    masked_butterfly1x2 i_bf1x2 (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .u00_sh_i      (u00_sh),
        .v00_sh_i      (v00_sh),
        .u01_sh_i      (u01_sh),
        .v01_sh_i      (v01_sh),
        .w0_i          (w_dly[0]),
        .w1_i          (w_dly[1]),
        .refresh_rnd_i (refresh_rnd),
        .u20_o         (u20_o),
        .u21_o         (u21_o),
        .v20_o         (v20_o),
        .v21_o         (v21_o)
    );

    pipe_delay #(
        .T     (logic),
        .DEPTH (STAGE_LAT)
    ) i_valid_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .d_i       (valid_i),
        .q_o       (valid_o)
    );

endmodule

/* bench/tb_intt_stage1.sv */
/*
 * Testbench for the masked INTT stage 1 top level
 * Drives directed, random, mask-invariance and zeroize sequences and
 * checks every result against a plain modulo-q butterfly model
 */
`timescale 1ns/1ps

module tb_intt_stage1
    import intt_mask_pkg::*;
;

    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DLY      = 2;
    localparam int RESET_CYCLES   = 5;
    localparam int NUM_TESTS      = 5;
    localparam int IDLE_CYCLES    = 10;
    localparam int NUM_DIRECTED   = 4;
    localparam int NUM_RANDOM     = 200;
    localparam int NUM_INVARIANCE = 4;
    localparam int NUM_ZEROIZE    = 8;
    localparam int NUM_OPS        = NUM_DIRECTED + NUM_RANDOM + NUM_INVARIANCE + NUM_ZEROIZE;
    // Directed operations drain one by one, the margin absorbs that
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_OPS + STAGE_LAT * NUM_TESTS
                                    + IDLE_CYCLES + 2 * STAGE_LAT + 100;

    logic                 clk;
    logic                 reset_n;
    logic                 zeroize_i;
    logic                 valid_i;
    logic [Q_WIDTH-1:0]   u00_i;
    logic [Q_WIDTH-1:0]   v00_i;
    logic [Q_WIDTH-1:0]   u01_i;
    logic [Q_WIDTH-1:0]   v01_i;
    logic [Q_WIDTH-1:0]   w0_i;
    logic [Q_WIDTH-1:0]   w1_i;
    logic [RND_WIDTH-1:0] rnd_i;
    logic                 valid_o;
    logic [Q_WIDTH-1:0]   u20_o;
    logic [Q_WIDTH-1:0]   u21_o;
    logic [Q_WIDTH-1:0]   v20_o;
    logic [Q_WIDTH-1:0]   v21_o;

    string test_names [NUM_TESTS] = '{"after_reset", "directed", "random_stream",
                                      "mask_invariance", "zeroize"};
    string field_names [COEFS] = '{"u20", "u21", "v20", "v21"};
    int    checks [NUM_TESTS] = '{default: 0};
    int    errors [NUM_TESTS] = '{default: 0};
    int    cur_test;
    int    cycle_count;

    logic [15:0]          lfsr_state = 16'd31;
    logic [COEFS*Q_WIDTH-1:0] exp_q [$];
    int                   test_q [$];
    logic [COEFS*Q_WIDTH-1:0] chk_exp;
    logic [COEFS*Q_WIDTH-1:0] chk_act;
    int                   chk_test;
    logic                 chk_pending;
    logic                 idle_expected;
    logic [STAGE_LAT-1:0] zero_hist;

    intt_stage1_top i_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .valid_i   (valid_i),
        .u00_i     (u00_i),
        .v00_i     (v00_i),
        .u01_i     (u01_i),
        .v01_i     (v01_i),
        .w0_i      (w0_i),
        .w1_i      (w1_i),
        .rnd_i     (rnd_i),
        .valid_o   (valid_o),
        .u20_o     (u20_o),
        .u21_o     (u21_o),
        .v20_o     (v20_o),
        .v21_o     (v21_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [RND_WIDTH-1:0] rand_bits(input int nbits);
        logic [RND_WIDTH-1:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v = {v[RND_WIDTH-2:0], lfsr_next_bit()};
        end
        return v;
    endfunction

    function automatic int draw_coef();
        int x;
        x = int'(rand_bits(Q_WIDTH));
        if (x >= MLKEM_Q) begin
            x = x - MLKEM_Q;
        end
        return x;
    endfunction

    function automatic int half_q(input int x);
        if (x % 2 == 0) begin
            return x / 2;
        end
        return (x + MLKEM_Q) / 2;
    endfunction

    // GS butterfly on plain values, then halving; packed as v21, v20, u21, u20
    function automatic logic [COEFS*Q_WIDTH-1:0] model_outputs(input int u00, input int v00,
                                                          input int u01, input int v01,
                                                          input int w0, input int w1);
        int r [COEFS];
        r[0] = half_q((u00 + v00) % MLKEM_Q);
        r[1] = half_q((((u00 - v00 + MLKEM_Q) % MLKEM_Q) * w0) % MLKEM_Q);
        r[2] = half_q((u01 + v01) % MLKEM_Q);
        r[3] = half_q((((u01 - v01 + MLKEM_Q) % MLKEM_Q) * w1) % MLKEM_Q);
        return {Q_WIDTH'(r[3]), Q_WIDTH'(r[2]), Q_WIDTH'(r[1]), Q_WIDTH'(r[0])};
    endfunction

    // Inputs rest at zero between strobes so idle outputs stay zero
    task automatic drive_idle_inputs();
        valid_i = 1'b0;
        u00_i   = '0;
        v00_i   = '0;
        u01_i   = '0;
        v01_i   = '0;
        w0_i    = '0;
        w1_i    = '0;
        rnd_i   = '0;
    endtask

    task automatic send_op(input int u00, input int v00, input int u01, input int v01,
                           input int w0, input int w1, input logic [RND_WIDTH-1:0] rnd);
        u00_i   = Q_WIDTH'(u00);
        v00_i   = Q_WIDTH'(v00);
        u01_i   = Q_WIDTH'(u01);
        v01_i   = Q_WIDTH'(v01);
        w0_i    = Q_WIDTH'(w0);
        w1_i    = Q_WIDTH'(w1);
        rnd_i   = rnd;
        valid_i = 1'b1;
        exp_q.push_back(model_outputs(u00, v00, u01, v01, w0, w1));
        test_q.push_back(cur_test);
        @(posedge clk);
        #DRIVE_DLY;
        drive_idle_inputs();
    endtask

    task automatic send_random_op();
        send_op(draw_coef(), draw_coef(), draw_coef(), draw_coef(),
                draw_coef(), draw_coef(), rand_bits(RND_WIDTH));
    endtask

    // One extra edge lets the last comparison finish
    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic watch_idle(input int cycles);
        idle_expected = 1'b1;
        repeat (cycles) begin
            @(posedge clk);
            checks[cur_test]++;
        end
        #DRIVE_DLY;
        idle_expected = 1'b0;
    endtask

    task automatic close_test();
        $display("Test %0d %s: %0d checks, %0d errors",
                 cur_test, test_names[cur_test], checks[cur_test], errors[cur_test]);
    endtask

    task automatic log_mismatch();
        for (int f = 0; f < COEFS; f++) begin
            if (chk_act[f*Q_WIDTH +: Q_WIDTH] != chk_exp[f*Q_WIDTH +: Q_WIDTH]) begin
                $display("FAIL %s %s: expected %0d, actual %0d", test_names[chk_test],
                         field_names[f], chk_exp[f*Q_WIDTH +: Q_WIDTH],
                         chk_act[f*Q_WIDTH +: Q_WIDTH]);
            end
        end
        errors[chk_test]++;
    endtask

    task automatic flag_valid_timing();
        $display("Error in %s at %0t: valid_o was not %0d cycles behind valid_i",
                 test_names[cur_test], $time, STAGE_LAT);
        errors[cur_test]++;
    endtask

    task automatic flag_busy_outputs();
        $display("Error in %s at %0t: outputs not idle and zero when no result was due",
                 test_names[cur_test], $time);
        errors[cur_test]++;
    endtask

    // Zeroize sampled within the last STAGE_LAT edges drops the result
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            zero_hist <= '0;
        end else begin
            zero_hist <= {zero_hist[STAGE_LAT-2:0], zeroize_i};
        end
    end

    // Capture results mid-cycle so the assertion sees stable values
    always @(negedge clk) begin
        chk_pending = 1'b0;
        if (reset_n && valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: valid_o with no operation in flight", $time);
                errors[cur_test]++;
            end else begin
                chk_exp     = exp_q.pop_front();
                chk_test    = test_q.pop_front();
                chk_act     = {v21_o, v20_o, u21_o, u20_o};
                chk_pending = 1'b1;
                checks[chk_test]++;
            end
        end
    end

    valid_follows_strobe: assert property (@(posedge clk) disable iff (!reset_n)
        valid_o == ($past(valid_i, STAGE_LAT) && (zero_hist == '0)))
        else flag_valid_timing();

    result_matches_model: assert property (@(posedge clk) disable iff (!reset_n)
        chk_pending |-> (chk_act == chk_exp))
        else log_mismatch();

    idle_outputs_zero: assert property (@(posedge clk) disable iff (!reset_n)
        idle_expected |-> (!valid_o && u20_o == '0 && u21_o == '0 &&
                           v20_o == '0 && v21_o == '0))
        else flag_busy_outputs();

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        int total_checks;
        int total_errors;
        reset_n       = 1'b0;
        zeroize_i     = 1'b0;
        valid_i       = 1'b0;
        u00_i         = '0;
        v00_i         = '0;
        u01_i         = '0;
        v01_i         = '0;
        w0_i          = '0;
        w1_i          = '0;
        rnd_i         = '0;
        chk_pending   = 1'b0;
        idle_expected = 1'b1;
        cur_test      = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset_n = 1'b1;

        watch_idle(IDLE_CYCLES);
        close_test();

        cur_test = 1;
        send_op(0, 0, 0, 0, 0, 0, rand_bits(RND_WIDTH));
        wait_drained();
        send_op(1234, 1234, 3328, 3328, 1729, 2642, rand_bits(RND_WIDTH));
        wait_drained();
        send_op(1, 1, 0, 0, 3328, 1, rand_bits(RND_WIDTH));
        wait_drained();
        send_op(5, 3000, 3328, 0, 3328, 17, rand_bits(RND_WIDTH));
        wait_drained();
        close_test();

        cur_test = 2;
        repeat (NUM_RANDOM) send_random_op();
        wait_drained();
        close_test();

        // Mask words at 4095 and exactly q both need the reduction step
        cur_test = 3;
        send_op(3328, 1, 1700, 2900, 1729, 17, {RND_WIDTH{1'b1}});
        send_op(3328, 1, 1700, 2900, 1729, 17, rand_bits(RND_WIDTH));
        send_op(42, 2048, 3000, 7, 3328, 2, {RND_WORDS{12'd3329}});
        send_op(42, 2048, 3000, 7, 3328, 2, rand_bits(RND_WIDTH));
        wait_drained();
        close_test();

        cur_test = 4;
        repeat (NUM_ZEROIZE / 2) send_random_op();
        zeroize_i = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        zeroize_i = 1'b0;
        exp_q.delete();
        test_q.delete();
        watch_idle(2 * STAGE_LAT);
        repeat (NUM_ZEROIZE / 2) send_random_op();
        wait_drained();
        close_test();

        total_checks = 0;
        total_errors = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 NUM_TESTS, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* files.f */
hdl/intt_mask_pkg.sv
hdl/pipe_delay.sv
hdl/mod_mul_q.sv
hdl/mask_share_split.sv
hdl/masked_gs_butterfly.sv
hdl/masked_butterfly1x2.sv
hdl/intt_stage1_top.sv
bench/tb_intt_stage1.sv

/* Makefile */
# Verilator build, run and lint for the masked INTT stage 1 testbench

VERILATOR ?= verilator
TOP       ?= tb_intt_stage1
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
